/* Makefile */
SIM = obj_dir/VtbPs2Kbd

all: run

compile: $(SIM)

$(SIM): src.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tbPs2Kbd -f src.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* kbdAsciiRom.sv */
`timescale 1ns/10ps
`default_nettype none

module kbdAsciiRom import kbdCodePkg::*; (
	input  scanCodeT addr,
	output charCodeT data
);

	always_comb begin
		unique case (addr)
			8'h1C: data = 8'h61; // a
			8'h32: data = 8'h62;
			8'h21: data = 8'h63;
			8'h23: data = 8'h64;
			8'h24: data = 8'h65;
			8'h2B: data = 8'h66;
			8'h34: data = 8'h67;
			8'h33: data = 8'h68;
			8'h43: data = 8'h69;
			8'h3B: data = 8'h6A;
			8'h42: data = 8'h6B;
			8'h4B: data = 8'h6C;
			8'h3A: data = 8'h6D;
			8'h31: data = 8'h6E;
			8'h44: data = 8'h6F;
			8'h4D: data = 8'h70;
			8'h15: data = 8'h71;
			8'h2D: data = 8'h72;
			8'h1B: data = 8'h73;
			8'h2C: data = 8'h74;
			8'h3C: data = 8'h75;
			8'h2A: data = 8'h76;
			8'h1D: data = 8'h77;
			8'h22: data = 8'h78;
			8'h35: data = 8'h79;
			8'h1A: data = 8'h7A; // z
			8'h45: data = 8'h30; // 0
			8'h16: data = 8'h31;
			8'h1E: data = 8'h32;
			8'h26: data = 8'h33;
			8'h25: data = 8'h34;
			8'h2E: data = 8'h35;
			8'h36: data = 8'h36;
			8'h3D: data = 8'h37;
			8'h3E: data = 8'h38;
			8'h46: data = 8'h39; // 9
			8'h0E: data = 8'h60; // backtick
			8'h4E: data = 8'h2D; // minus
			8'h55: data = 8'h3D; // equals
			8'h54: data = 8'h5B; // [
			8'h5B: data = 8'h5D; // ]
			8'h5D: data = 8'h5C; // backslash
			8'h4C: data = 8'h3B; // ;
			8'h52: data = 8'h27; // quote
			8'h41: data = 8'h2C; // comma
			8'h49: data = 8'h2E; // period
			8'h4A: data = 8'h2F; // slash
			8'h0D: data = 8'd9; // tab
			8'h29: data = 8'd32; // space
			8'h66: data = 8'd8; // backspace
			8'h5A: data = 8'd13; // enter
			8'h76: data = 8'd27; // escape
			8'h71: data = 8'd46; // delete, E0 71
			8'h77: data = 8'd144; // num lock
			// arrows arrive with the E0 prefix
			8'h6B: data = 8'd37;
			8'h75: data = 8'd38;
			8'h74: data = 8'd39;
			8'h72: data = 8'd40;
			// modifiers, host key codes
			8'h12: data = 8'd16; // left shift
			8'h59: data = 8'd16; // right shift
			8'h14: data = 8'd17; // ctrl
			8'h11: data = 8'd18; // alt
			8'h58: data = 8'd20; // caps lock
			// function keys, set 2 order is scattered
			8'h05: data = 8'd112; // F1
			8'h06: data = 8'd113;
			8'h04: data = 8'd114;
			8'h0C: data = 8'd115;
			8'h03: data = 8'd116;
			8'h0B: data = 8'd117;
			8'h83: data = 8'd118; // F7
			8'h0A: data = 8'd119;
			8'h01: data = 8'd120;
			8'h09: data = 8'd121;
			8'h78: data = 8'd122;
			8'h07: data = 8'd123; // F12
			default: data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

/* kbdBusPkg.sv */
`default_nettype none
`include "kbdCfg_cfg.svh"

package kbdBusPkg;

	typedef logic [`KBD_APB_AW-1:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	localparam apbAddrT REG_DATA   = 4'h0; // fifo head, read pops
	localparam apbAddrT REG_STATUS = 4'h4;
	localparam apbAddrT REG_CTRL   = 4'h8;

	// STATUS fields
	localparam int STS_OVERFLOW = 4; // w1c
	localparam int STS_RXERR    = 5; // w1c
	localparam int STS_SHIFT    = 6;
	localparam int STS_CAPS     = 7;

	// CTRL fields
	localparam int CTRL_EN    = 0;
	localparam int CTRL_IRQEN = 1;

	// DATA word
	localparam int DATA_VALID = 10;

endpackage

`default_nettype wire

/* kbdCfg_cfg.svh */
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// key event FIFO entries
`define KBD_FIFO_DEPTH 8

// APB byte address width
`define KBD_APB_AW 4

// equal samples before a PS/2 line level is taken
`define KBD_FILT_LEN 4

`endif

/* kbdCodePkg.sv */
`default_nettype none

package kbdCodePkg;

	typedef logic [7:0] scanCodeT; // raw set-2 byte
	typedef logic [7:0] charCodeT; // ascii or host key code

	// {extended, break, char}
	typedef logic [9:0] keyEventT;

	localparam int EV_BRK_BIT = 8;
	localparam int EV_EXT_BIT = 9;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rxStateT;

	localparam scanCodeT SC_BREAK  = 8'hF0; // break prefix
	localparam scanCodeT SC_EXT    = 8'hE0; // extended prefix
	localparam scanCodeT SC_LSHIFT = 8'h12;
	localparam scanCodeT SC_RSHIFT = 8'h59;
	localparam scanCodeT SC_CAPS   = 8'h58;

endpackage

`default_nettype wire

/* kbdIfs.sv */
`timescale 1ns/10ps
`default_nettype none

// receiver byte strobe with error flags
interface scanIf import kbdCodePkg::*; ();
	logic valid; // one clk pulse per frame
	scanCodeT code;
	logic parityErr;
	logic frameErr; // bad start or stop bit

	modport producer (output valid, code, parityErr, frameErr);
	modport consumer (input valid, code, parityErr, frameErr);
	modport monitor (input valid, parityErr, frameErr); // error tap only
endinterface

// decoded key event towards the host side
interface keyIf import kbdCodePkg::*; ();
	logic valid;
	keyEventT evt;
	logic shiftOn; // level
	logic capsOn; // level

	modport producer (output valid, evt, shiftOn, capsOn);
	modport consumer (input valid, evt, shiftOn, capsOn);
endinterface

`default_nettype wire

/* keyFifoApb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "kbdCfg_cfg.svh"

module keyFifoApb import kbdCodePkg::*; import kbdBusPkg::*; (
	input  logic clk,
	input  logic arstN,
	keyIf.consumer key,
	scanIf.monitor scan,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  apbAddrT paddr,
	input  apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);
	localparam int PTR_W = $clog2(`KBD_FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = `KBD_FIFO_DEPTH;

	keyEventT mem [`KBD_FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;
	logic enable;
	logic irqEn;
	logic overflow; // sticky
	logic rxErr; // sticky
	logic access;
	logic mapped;
	logic pop;
	logic push;
	logic pushOk;

	assign access = psel & penable;
	assign mapped = (paddr == REG_DATA) || (paddr == REG_STATUS) || (paddr == REG_CTRL);
	assign pop = access && !pwrite && paddr == REG_DATA && count != '0;
	assign push = key.valid & enable;
	assign pushOk = push && (count != FULL_CNT || pop); // full but popping frees a slot

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1; // power-of-two depth wraps by itself
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (pushOk && !pop)
				count <= count + 1'b1;
			else if (pop && !pushOk)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pushOk)
			mem[wrPtr] <= key.evt;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			enable <= 1'b1;
			irqEn <= 1'b0;
			overflow <= 1'b0;
			rxErr <= 1'b0;
		end else begin
			if (access && pwrite && paddr == REG_CTRL) begin
				enable <= pwdata[CTRL_EN];
				irqEn <= pwdata[CTRL_IRQEN];
			end
			// set beats clear in the same cycle
			if (push && !pushOk)
				overflow <= 1'b1;
			else if (access && pwrite && paddr == REG_STATUS && pwdata[STS_OVERFLOW])
				overflow <= 1'b0;
			if (scan.valid && (scan.parityErr || scan.frameErr))
				rxErr <= 1'b1;
			else if (access && pwrite && paddr == REG_STATUS && pwdata[STS_RXERR])
				rxErr <= 1'b0;
		end
	end

	always_comb begin
		prdata = '0;
		unique case (paddr)
			REG_DATA: begin
				if (count != '0) begin
					prdata[9:0] = mem[rdPtr];
					prdata[DATA_VALID] = 1'b1;
				end
			end
			REG_STATUS: begin
				prdata[PTR_W:0] = count;
				prdata[STS_OVERFLOW] = overflow;
				prdata[STS_RXERR] = rxErr;
				prdata[STS_SHIFT] = key.shiftOn;
				prdata[STS_CAPS] = key.capsOn;
			end
			REG_CTRL: begin
				prdata[CTRL_EN] = enable;
				prdata[CTRL_IRQEN] = irqEn;
			end
			default: prdata = '0;
		endcase
	end

	assign pready = 1'b1; // no wait states
	assign pslverr = access & ~mapped;
	assign irq = irqEn & (count != '0);

endmodule

`default_nettype wire

/* ps2KbdChk_chk.sv */
`timescale 1ns/10ps
`default_nettype none
`include "kbdCfg_cfg.svh"

module ps2KbdChk (
	input  logic clk,
	input  logic arstN,
	input  logic psel,
	input  logic penable,
	input  logic pslverr,
	input  logic push,
	input  logic pop,
	input  logic irqEn,
	input  logic irq,
	input  logic [$clog2(`KBD_FIFO_DEPTH):0] count
);
	int failCnt = 0; // assertion failures so far

	// an access cycle comes right after its setup cycle
	errInAccess: assert property (@(posedge clk) disable iff (!arstN)
		pslverr |-> (psel && penable && $past(psel && !penable)))
	else begin
		$error("pslverr raised outside an APB access cycle");
		failCnt = failCnt + 1;
	end

	countBound: assert property (@(posedge clk) disable iff (!arstN)
		int'(count) <= `KBD_FIFO_DEPTH)
	else begin
		$error("FIFO count above its depth");
		failCnt = failCnt + 1;
	end

	// irq state after a push or after popping the last entry
	irqLevel: assert property (@(posedge clk) disable iff (!arstN)
		(push || (pop && count == 1)) |=> (irq == (irqEn && $past(push))))
	else begin
		$error("irq does not match irqEn and a non-empty FIFO");
		failCnt = failCnt + 1;
	end

endmodule

bind keyFifoApb ps2KbdChk chk0 (
	.clk(clk),
	.arstN(arstN),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.push(push),
	.pop(pop),
	.irqEn(irqEn),
	.irq(irq),
	.count(count)
);

`default_nettype wire

/* ps2KbdTop.sv */
`timescale 1ns/10ps
`default_nettype none

module ps2KbdTop import kbdBusPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic ps2Clk,
	input  logic ps2Data,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  apbAddrT paddr,
	input  apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	scanIf scanBus ();
	keyIf keyBus ();

	ps2Rx rx0 (
		.clk(clk),
		.arstN(arstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.scan(scanBus.producer)
	);

	scanDecode dec0 (
		.clk(clk),
		.arstN(arstN),
		.scan(scanBus.consumer),
		.key(keyBus.producer)
	);

	// taps scanBus for the rxErr sticky bit
	keyFifoApb fifo0 (
		.clk(clk),
		.arstN(arstN),
		.key(keyBus.consumer),
		.scan(scanBus.monitor),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq)
	);

endmodule

`default_nettype wire

/* ps2Rx.sv */
`timescale 1ns/10ps
`default_nettype none
`include "kbdCfg_cfg.svh"

module ps2Rx import kbdCodePkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic ps2Clk,
	input  logic ps2Data,
	scanIf.producer scan
);
	logic [1:0] sync1; // [0] clock line, [1] data line
	logic [1:0] sync2;
	logic [1:0][`KBD_FILT_LEN-1:0] hist;
	logic [1:0] filt; // accepted line levels
	logic clkPrev;
	logic fallEdge;
	rxStateT state;
	logic [2:0] bitCnt;
	scanCodeT shiftReg;
	logic startBit;
	logic parityBit;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sync1 <= '1; // idle bus is high
			sync2 <= '1;
			hist <= '1;
			filt <= '1;
			clkPrev <= 1'b1;
		end else begin
			sync1 <= {ps2Data, ps2Clk};
			sync2 <= sync1;
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][`KBD_FILT_LEN-2:0], sync2[i]};
				if (&hist[i])
					filt[i] <= 1'b1;
				else if (!(|hist[i]))
					filt[i] <= 1'b0; // otherwise hold the old level
			end
			clkPrev <= filt[0];
		end
	end

	assign fallEdge = clkPrev & ~filt[0]; // device changes data on rising, we sample here

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= RX_IDLE;
			bitCnt <= '0;
			startBit <= 1'b0;
			scan.valid <= 1'b0;
			scan.parityErr <= 1'b0;
			scan.frameErr <= 1'b0;
		end else begin
			scan.valid <= 1'b0;
			if (fallEdge) begin
				unique case (state)
					RX_IDLE: begin
						startBit <= filt[1]; // must be 0, checked at stop
						bitCnt <= '0;
						state <= RX_DATA;
					end
					RX_DATA: begin
						bitCnt <= bitCnt + 3'd1;
						if (bitCnt == 3'd7)
							state <= RX_PARITY;
					end
					RX_PARITY: state <= RX_STOP;
					RX_STOP: begin
						scan.valid <= 1'b1;
						scan.parityErr <= ~(^{shiftReg, parityBit}); // odd parity
						scan.frameErr <= startBit | ~filt[1];
						state <= RX_IDLE;
					end
				endcase
			end
		end
	end

	// data path, no reset
	always_ff @(posedge clk) begin
		if (fallEdge && state == RX_DATA)
			shiftReg <= {filt[1], shiftReg[7:1]}; // lsb first
		if (fallEdge && state == RX_PARITY)
			parityBit <= filt[1];
		if (fallEdge && state == RX_STOP)
			scan.code <= shiftReg;
	end

endmodule

`default_nettype wire

/* scanDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module scanDecode import kbdCodePkg::*; (
	input  logic clk,
	input  logic arstN,
	scanIf.consumer scan,
	keyIf.producer key
);
	charCodeT romChar;
	charCodeT outChar;
	logic brkPend; // F0 seen
	logic extPend; // E0 seen
	logic shiftOn;
	logic capsOn;
	logic isLetter;
	logic isShift;
	logic badByte;

	kbdAsciiRom rom0 (
		.addr(scan.code),
		.data(romChar)
	);

	// F1..F11 map into 0x70..0x7A too, so also look at the scan code range
	assign isLetter = (romChar >= 8'h61) && (romChar <= 8'h7A) &&
		(scan.code >= 8'h10) && (scan.code < 8'h50);
	assign outChar = (isLetter && (shiftOn ^ capsOn)) ? romChar - 8'h20 : romChar;
	assign isShift = !extPend && (scan.code == SC_LSHIFT || scan.code == SC_RSHIFT);
	assign badByte = scan.parityErr | scan.frameErr;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			brkPend <= 1'b0;
			extPend <= 1'b0;
			shiftOn <= 1'b0;
			capsOn <= 1'b0;
			key.valid <= 1'b0;
		end else begin
			key.valid <= 1'b0;
			if (scan.valid) begin
				if (badByte) begin
					brkPend <= 1'b0; // resync on the next clean byte
					extPend <= 1'b0;
				end else if (scan.code == SC_BREAK) begin
					brkPend <= 1'b1;
				end else if (scan.code == SC_EXT) begin
					extPend <= 1'b1;
				end else begin
					key.valid <= 1'b1;
					if (isShift)
						shiftOn <= ~brkPend;
					if (scan.code == SC_CAPS && !brkPend)
						capsOn <= ~capsOn; // toggles on make only
					brkPend <= 1'b0;
					extPend <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan.valid && !badByte && scan.code != SC_BREAK && scan.code != SC_EXT)
			key.evt <= {extPend, brkPend, outChar};
	end

	assign key.shiftOn = shiftOn;
	assign key.capsOn = capsOn;

endmodule

`default_nettype wire

/* src.f */
+incdir+.
kbdCodePkg.sv
kbdBusPkg.sv
kbdIfs.sv
ps2Rx.sv
kbdAsciiRom.sv
scanDecode.sv
keyFifoApb.sv
ps2KbdTop.sv
ps2KbdChk_chk.sv
tbPs2Kbd.sv

/* tbPs2Kbd.sv */
`timescale 1ns/10ps
`default_nettype none

module tbPs2Kbd import kbdBusPkg::*; ();
	localparam int HALF_CYC = 50; // 1 us half period of the PS/2 clock
	localparam int GAP_CYC = 200; // idle line after each frame
	localparam int N_ENT = 10;
	localparam int N_DIRECT_FRAMES = 12; // overflow, enable and irq steps
	localparam int POLL_MAX = 400;

	logic clk;
	logic arstN;
	logic ps2Clk;
	logic ps2Data;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddrT paddr;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;
	logic irq;

	string entName [N_ENT];
	int entLen [N_ENT];
	logic [7:0] entSeq [N_ENT][2];
	logic entBad [N_ENT];
	apbDataT entData [N_ENT]; // {valid, ext, brk, char}
	apbDataT entStatus [N_ENT]; // after the DATA read
	int nEnt = 0;
	int errors = 0;
	int checks = 0;

	ps2KbdTop dut0 (
		.clk(clk),
		.arstN(arstN),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// keyboard model moves data while the clock is high
	task automatic sendByte(input logic [7:0] b, input logic badParity);
		logic [10:0] frame;
		logic par;
		par = ~(^b) ^ badParity; // odd parity
		frame = {1'b1, par, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2Data = frame[i];
			tick(HALF_CYC);
			ps2Clk = 1'b0;
			tick(HALF_CYC);
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;
		tick(GAP_CYC);
	endtask

	task automatic apbWrite(input apbAddrT addr, input apbDataT data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		tick(1);
		penable = 1'b1;
		tick(1);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		tick(1);
		penable = 1'b1;
		#8; // middle of the access cycle
		data = prdata;
		err = pslverr;
		tick(1);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic checkValue(input string name, input apbDataT exp, input apbDataT act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	// polls STATUS until an event or a receive error shows up
	task automatic waitEvent(input string name);
		apbDataT sts;
		logic err;
		int tries;
		sts = '0;
		tries = 0;
		while (sts[3:0] == 4'd0 && !sts[STS_RXERR] && tries < POLL_MAX) begin
			apbRead(REG_STATUS, sts, err);
			tries++;
		end
		assert (sts[3:0] != 4'd0 || sts[STS_RXERR]) else begin
			$display("%s: neither a key event nor a receive error reached STATUS", name);
			errors++;
		end
	endtask

	task automatic addEntry(input string name, input int len, input logic [7:0] b0,
		input logic [7:0] b1, input logic bad, input apbDataT expData, input apbDataT expSts);
		entName[nEnt] = name;
		entLen[nEnt] = len;
		entSeq[nEnt][0] = b0;
		entSeq[nEnt][1] = b1;
		entBad[nEnt] = bad;
		entData[nEnt] = expData;
		entStatus[nEnt] = expSts;
		nEnt++;
	endtask

	// set-2 make codes of the letters a to j
	function automatic logic [7:0] letterScan(input int i);
		case (i)
			0: return 8'h1C;
			1: return 8'h32;
			2: return 8'h21;
			3: return 8'h23;
			4: return 8'h24;
			5: return 8'h2B;
			6: return 8'h34;
			7: return 8'h33;
			8: return 8'h43;
			default: return 8'h3B;
		endcase
	endfunction

	initial begin
		apbDataT rd;
		logic err;
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		arstN = 1'b0;

		addEntry("make a", 1, 8'h1C, 8'h00, 1'b0, 32'h461, 32'h00);
		addEntry("break a", 2, 8'hF0, 8'h1C, 1'b0, 32'h561, 32'h00);
		addEntry("extended up", 2, 8'hE0, 8'h75, 1'b0, 32'h626, 32'h00);
		addEntry("shift make", 1, 8'h12, 8'h00, 1'b0, 32'h410, 32'h40);
		addEntry("shifted a", 1, 8'h1C, 8'h00, 1'b0, 32'h441, 32'h40);
		addEntry("caps make", 1, 8'h58, 8'h00, 1'b0, 32'h414, 32'hC0);
		addEntry("shift break", 2, 8'hF0, 8'h12, 1'b0, 32'h510, 32'h80);
		addEntry("caps a", 1, 8'h1C, 8'h00, 1'b0, 32'h441, 32'h80);
		addEntry("bad parity", 1, 8'h1C, 8'h00, 1'b1, 32'h000, 32'hA0);
		addEntry("caps off", 1, 8'h58, 8'h00, 1'b0, 32'h414, 32'h00);

		tick(2);
		arstN = 1'b1;
		tick(2);

		for (int e = 0; e < nEnt; e++) begin
			for (int k = 0; k < entLen[e]; k++)
				sendByte(entSeq[e][k], entBad[e]);
			waitEvent(entName[e]);
			apbRead(REG_DATA, rd, err);
			checkValue(entName[e], entData[e], rd);
			checkValue({entName[e], " pslverr"}, 32'h0, {31'h0, err});
			apbRead(REG_STATUS, rd, err);
			checkValue({entName[e], " status"}, entStatus[e], rd);
			if (entBad[e]) begin
				apbWrite(REG_STATUS, 32'h1 << STS_RXERR);
				apbRead(REG_STATUS, rd, err);
				checkValue({entName[e], " rxErr clear"},
					entStatus[e] & ~(32'h1 << STS_RXERR), rd);
			end
		end

		// ten keys into an eight deep FIFO
		for (int i = 0; i < 10; i++)
			sendByte(letterScan(i), 1'b0);
		waitEvent("overflow");
		apbRead(REG_STATUS, rd, err);
		checkValue("overflow status", 32'h18, rd);
		for (int i = 0; i < 8; i++) begin
			apbRead(REG_DATA, rd, err);
			checkValue("overflow order", {21'h0, 1'b1, 2'b00, 8'h61 + 8'(i)}, rd);
		end
		apbRead(REG_DATA, rd, err);
		checkValue("empty read valid", 32'h0, {31'h0, rd[DATA_VALID]});
		apbWrite(REG_STATUS, 32'h1 << STS_OVERFLOW);
		apbRead(REG_STATUS, rd, err);
		checkValue("overflow clear", 32'h0, rd);

		apbWrite(REG_CTRL, 32'h0); // pushes off
		sendByte(8'h1C, 1'b0);
		apbRead(REG_STATUS, rd, err);
		checkValue("disabled count", 32'h0, rd);
		apbWrite(REG_CTRL, 32'h3);
		checkValue("irq idle", 32'h0, {31'h0, irq});
		sendByte(8'h1C, 1'b0);
		waitEvent("irq event");
		checkValue("irq pending", 32'h1, {31'h0, irq});
		apbRead(REG_DATA, rd, err);
		checkValue("irq data", 32'h461, rd);
		checkValue("irq cleared", 32'h0, {31'h0, irq});
		apbRead(4'hC, rd, err);
		checkValue("unmapped pslverr", 32'h1, {31'h0, err});
		checkValue("pready", 32'h1, {31'h0, pready});

		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, dut0.fifo0.chk0.failCnt);
		if (errors == 0 && dut0.fifo0.chk0.failCnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// about 40 us per frame plus margin
	initial begin
		int frames;
		int limitNs;
		#1;
		frames = N_DIRECT_FRAMES;
		for (int e = 0; e < nEnt; e++)
			frames += entLen[e];
		limitNs = frames * 40000 + 200000;
		#(limitNs);
		$display("timeout: the run did not finish within %0d us", limitNs / 1000);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
